/* api_pkg.sv */
package api_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------
  localparam int API_NUM  = 4;   // chips on the shared spi link
  localparam int ID_W     = 2;   // chip index width
  localparam int TX_DEPTH = 64;  // work words
  localparam int RX_DEPTH = 16;  // nonce records
  localparam int CNT_W    = 7;   // fifo count, must hold 64

  typedef logic [31:0] word_t;

  // nonce as stored in the rx fifo
  typedef struct packed {
    logic [ID_W-1:0] miner_id;  // chip that answered
    word_t           nonce;
  } nonce_rec_t;

  // host config, levels from slave to ctrl
  typedef struct packed {
    logic [27:0] timeout;   // gap between jobs, clk cycles
    logic [7:0]  sck_div;   // half period = sck_div+1
    logic [2:0]  ch_num;    // chips in rotation
    logic [7:0]  word_num;  // words per job
  } api_cfg_t;

  // wishbone request side
  typedef struct packed {
    logic       we;
    logic [5:0] adr;  // byte address
    word_t      dat;
  } wb_req_t;

  // --------------------------------------------------------------------------
  // register map
  // --------------------------------------------------------------------------
  localparam logic [5:0] ADR_DATA    = 6'h00;  // wr tx push, rd rx pop
  localparam logic [5:0] ADR_STATUS  = 6'h04;
  localparam logic [5:0] ADR_TIMEOUT = 6'h08;
  localparam logic [5:0] ADR_SCK     = 6'h0C;
  localparam logic [5:0] ADR_CHNUM   = 6'h10;
  localparam logic [5:0] ADR_WORDNUM = 6'h14;
  localparam logic [5:0] ADR_FLUSH   = 6'h18;
  localparam logic [5:0] ADR_MINER   = 6'h1C;  // rx head id, no pop

  localparam word_t ALL_ONES = '1;  // chip has nothing to report

endpackage

/* api_fifo.sv */
`timescale 1ns/1ns

module api_fifo import api_pkg::*; #(
  parameter type T     = word_t,
  parameter int  DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush,  // empties like a reset
  input  logic             push,
  input  T                 din,
  input  logic             pop,
  output T                 dout,   // head, combinational
  output logic             full,
  output logic             empty,
  output logic [CNT_W-1:0] count
);

  localparam int AW = $clog2(DEPTH);

  T            mem [DEPTH];  // payload storage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;   // push on full is lost
  assign do_pop  = pop & ~empty;   // pop on empty does nothing
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // occupancy bound, over any push/pop/flush history
  a_count_max: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH));

endmodule

/* api_slave.sv */
`timescale 1ns/1ns

module api_slave import api_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // wishbone
  input  logic             cyc,
  input  logic             stb,
  input  wb_req_t          wb_req,
  output logic             ack,
  output word_t            rd_dat,
  // config to ctrl
  output api_cfg_t         cfg,
  output logic             flush,
  // tx fifo write side
  output logic             tx_push,
  output word_t            tx_din,
  input  logic             tx_full,
  input  logic [CNT_W-1:0] tx_count,
  // rx fifo read side
  output logic             rx_pop,
  input  nonce_rec_t       rx_head,
  input  logic             rx_empty,
  input  logic [CNT_W-1:0] rx_count,
  input  logic             busy
);

  logic  accept;   // new transfer this cycle
  logic  wr_acc;
  logic  rd_acc;
  logic  tx_drop;  // sticky, push hit a full fifo
  word_t rd_nxt;

  assign accept = cyc & stb & ~ack;
  assign wr_acc = accept & wb_req.we;
  assign rd_acc = accept & ~wb_req.we;

  // data port side effects happen in the accept cycle
  assign tx_push = wr_acc & (wb_req.adr == ADR_DATA) & ~tx_full;
  assign tx_din  = wb_req.dat;
  assign rx_pop  = rd_acc & (wb_req.adr == ADR_DATA) & ~rx_empty;

  // --------------------------------------------------------------------------
  // read mux
  // --------------------------------------------------------------------------
  always_comb begin
    case (wb_req.adr)
      ADR_DATA:    rd_nxt = rx_empty ? ALL_ONES : rx_head.nonce;
      ADR_STATUS:  rd_nxt = word_t'({rx_count, tx_count, tx_drop, busy});
      ADR_TIMEOUT: rd_nxt = word_t'(cfg.timeout);
      ADR_SCK:     rd_nxt = word_t'(cfg.sck_div);
      ADR_CHNUM:   rd_nxt = word_t'(cfg.ch_num);
      ADR_WORDNUM: rd_nxt = word_t'(cfg.word_num);
      ADR_MINER:   rd_nxt = word_t'(rx_head.miner_id);  // peek only
      default:     rd_nxt = '0;  // flush and holes read zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_acc) rd_dat <= rd_nxt;  // valid with ack
  end

  // ack, one cycle after accept
  always_ff @(posedge clk) begin
    if (rst) ack <= 1'b0;
    else     ack <= accept;
  end

  // --------------------------------------------------------------------------
  // config registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.timeout  <= '0;
      cfg.sck_div  <= 8'd1;
      cfg.ch_num   <= 3'd1;
      cfg.word_num <= 8'd1;
    end else if (wr_acc) begin
      case (wb_req.adr)
        ADR_TIMEOUT: cfg.timeout  <= wb_req.dat[27:0];
        ADR_SCK:     cfg.sck_div  <= wb_req.dat[7:0];
        ADR_CHNUM:   cfg.ch_num   <= wb_req.dat[2:0];
        ADR_WORDNUM: cfg.word_num <= wb_req.dat[7:0];
        default:     ;
      endcase
    end
  end

  // flush pulse and tx_drop
  always_ff @(posedge clk) begin
    if (rst) begin
      flush   <= 1'b0;
      tx_drop <= 1'b0;
    end else begin
      flush <= wr_acc & (wb_req.adr == ADR_FLUSH) & wb_req.dat[0];
      if (flush)                                          tx_drop <= 1'b0;
      else if (wr_acc && wb_req.adr == ADR_DATA && tx_full) tx_drop <= 1'b1;
    end
  end

  // master drops stb in the ack cycle, so no back to back ack
  a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

/* api_spi_shift.sv */
`timescale 1ns/1ns

module api_spi_shift import api_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,    // taken when idle or with done
  input  word_t           tx_word,
  input  logic [ID_W-1:0] ch,
  input  logic [7:0]      sck_div,
  input  logic [API_NUM-1:0] miso,
  output logic            sck,
  output logic            mosi,
  output logic            done,
  output word_t           rx_word
);

  logic            busy;
  logic [7:0]      div_cnt;  // clk cycles into current half period
  logic [4:0]      bit_cnt;  // bit on mosi
  logic [ID_W-1:0] ch_q;     // miso select for this word
  word_t           tx_sh;
  word_t           rx_sh;
  logic            tick;     // sck toggles this edge

  assign tick    = busy & (div_cnt == sck_div);
  // last high half ends, all 32 samples are in
  assign done    = tick & sck & (bit_cnt == 5'd31);
  assign rx_word = rx_sh;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      sck     <= 1'b0;
      mosi    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (start && (!busy || done)) begin
      // next word follows without an extra low cycle
      busy    <= 1'b1;
      sck     <= 1'b0;
      mosi    <= tx_word[31];  // msb first, set up before first rise
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (done) begin
      busy <= 1'b0;
      sck  <= 1'b0;
    end else if (tick) begin
      div_cnt <= '0;
      sck     <= ~sck;
      if (sck) begin  // falling, next bit out
        bit_cnt <= bit_cnt + 1'b1;
        mosi    <= tx_sh[31];
      end
    end else if (busy) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // shift registers, no reset
  always_ff @(posedge clk) begin
    if (start && (!busy || done)) begin
      tx_sh <= {tx_word[30:0], 1'b0};
      ch_q  <= ch;
    end else if (tick) begin
      if (!sck) rx_sh <= {rx_sh[30:0], miso[ch_q]};  // rising, sample
      else      tx_sh <= {tx_sh[30:0], 1'b0};
    end
  end

  a_sck_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !sck);

endmodule

/* api_ctrl.sv */
`timescale 1ns/1ns

module api_ctrl import api_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  api_cfg_t           cfg,
  input  logic               flush,
  // tx fifo
  input  logic [CNT_W-1:0]   tx_count,
  input  word_t              tx_dout,
  output logic               tx_pop,
  // rx fifo
  input  logic               rx_full,
  output logic               rx_push,
  output nonce_rec_t         rx_din,
  // chips
  output logic [API_NUM-1:0] load,
  output logic               sck,
  output logic               mosi,
  input  logic [API_NUM-1:0] miso,
  output logic               busy,
  output logic               idle
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FRAME,  // load up, first word next
    ST_SHIFT,
    ST_GAP     // timeout between jobs
  } state_t;

  state_t          state;
  logic [7:0]      word_cnt;  // words started in this job
  logic [ID_W-1:0] ch;
  logic [2:0]      ch_inc;
  logic [27:0]     gap_cnt;
  logic            gap_zero;
  logic            job_ok;
  logic            spi_start;
  logic            spi_done;
  logic            last_word;
  word_t           spi_rx;

  assign gap_zero  = (gap_cnt == '0);
  assign job_ok    = ({1'b0, tx_count} >= cfg.word_num) & (cfg.word_num != '0) &
                     ~rx_full & gap_zero;
  assign last_word = (word_cnt == cfg.word_num);
  assign ch_inc    = {1'b0, ch} + 3'd1;

  // start the first word from frame, the rest back to back on done
  assign spi_start = (state == ST_FRAME) |
                     ((state == ST_SHIFT) & spi_done & ~last_word);
  assign tx_pop    = spi_start;

  // all ones means no nonce for this word
  assign rx_push = (state == ST_SHIFT) & spi_done & (spi_rx != ALL_ONES) & ~rx_full;
  assign rx_din  = '{miner_id: ch, nonce: spi_rx};

  assign busy = (state != ST_IDLE);
  assign idle = (state == ST_IDLE) & ({1'b0, tx_count} < cfg.word_num) & gap_zero;

  // --------------------------------------------------------------------------
  // job fsm
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state    <= ST_IDLE;
      load     <= '0;
      word_cnt <= '0;
      gap_cnt  <= '0;
      if (rst) ch <= '0;  // flush keeps rotation
    end else begin
      case (state)
        ST_IDLE: begin
          if (job_ok) begin
            state <= ST_FRAME;
            load  <= API_NUM'(1) << ch;  // one cycle ahead of first start
          end
        end
        ST_FRAME: begin
          state    <= ST_SHIFT;
          word_cnt <= 8'd1;
        end
        ST_SHIFT: begin
          if (spi_done) begin
            if (last_word) begin
              state   <= ST_GAP;
              load    <= '0;
              gap_cnt <= cfg.timeout;
              ch      <= (ch_inc >= cfg.ch_num) ? '0 : ch_inc[ID_W-1:0];  // wrap
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        ST_GAP: begin
          if (gap_zero) state <= ST_IDLE;
          else          gap_cnt <= gap_cnt - 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // flush also aborts a word in flight
  api_spi_shift spi_i (
    .clk     (clk),
    .rst     (rst | flush),
    .start   (spi_start),
    .tx_word (tx_dout),
    .ch      (ch),
    .sck_div (cfg.sck_div),
    .miso    (miso),
    .sck     (sck),
    .mosi    (mosi),
    .done    (spi_done),
    .rx_word (spi_rx)
  );

  // shared sck/mosi, only one chip framed at a time
  a_load_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(load));

endmodule

/* api.sv */
`timescale 1ns/1ns

module api import api_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // wishbone slave
  input  logic               cyc,
  input  logic               stb,
  input  wb_req_t            wb_req,
  output logic               ack,
  output word_t              rd_dat,
  // miner chips
  output logic [API_NUM-1:0] load,
  output logic               sck,
  output logic               mosi,
  input  logic [API_NUM-1:0] miso,
  output logic               api_idle
);

  api_cfg_t         cfg;
  logic             flush;
  logic             busy;

  // tx path, host words
  logic             tx_push;
  word_t            tx_din;
  logic             tx_pop;
  word_t            tx_dout;
  logic             tx_full;
  logic [CNT_W-1:0] tx_count;

  // rx path, nonce records
  logic             rx_push;
  nonce_rec_t       rx_din;
  logic             rx_pop;
  nonce_rec_t       rx_head;
  logic             rx_full;
  logic             rx_empty;
  logic [CNT_W-1:0] rx_count;

  // --------------------------------------------------------------------------
  // bus slave
  // --------------------------------------------------------------------------
  api_slave slave_i (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc),
    .stb      (stb),
    .wb_req   (wb_req),
    .ack      (ack),
    .rd_dat   (rd_dat),
    .cfg      (cfg),
    .flush    (flush),
    .tx_push  (tx_push),
    .tx_din   (tx_din),
    .tx_full  (tx_full),
    .tx_count (tx_count),
    .rx_pop   (rx_pop),
    .rx_head  (rx_head),
    .rx_empty (rx_empty),
    .rx_count (rx_count),
    .busy     (busy)
  );

  // --------------------------------------------------------------------------
  // fifos
  // --------------------------------------------------------------------------
  api_fifo #(.T(word_t), .DEPTH(TX_DEPTH)) tx_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .push  (tx_push),
    .din   (tx_din),
    .pop   (tx_pop),
    .dout  (tx_dout),
    .full  (tx_full),
    .empty (),          // ctrl goes by count
    .count (tx_count)
  );

  api_fifo #(.T(nonce_rec_t), .DEPTH(RX_DEPTH)) rx_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .push  (rx_push),
    .din   (rx_din),
    .pop   (rx_pop),
    .dout  (rx_head),
    .full  (rx_full),
    .empty (rx_empty),
    .count (rx_count)
  );

  api_ctrl ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .flush    (flush),
    .tx_count (tx_count),
    .tx_dout  (tx_dout),
    .tx_pop   (tx_pop),
    .rx_full  (rx_full),
    .rx_push  (rx_push),
    .rx_din   (rx_din),
    .load     (load),
    .sck      (sck),
    .mosi     (mosi),
    .miso     (miso),
    .busy     (busy),
    .idle     (api_idle)  // idle, short of a job, gap over
  );

endmodule

/* tb_api_chip.sv */
`timescale 1ns/1ns

module tb_api_chip import api_pkg::*; #(
  parameter int JOB_WORDS = 4  // words per job, same as the word_num register
) (
  input  logic [API_NUM-1:0] load,
  input  logic               sck,
  input  logic               mosi,
  output logic [API_NUM-1:0] miso
);

  int    job_chip[$];   // chip index of each job, arrival order
  word_t job_words[$];  // all received words, arrival order

  logic       any_load;
  logic       sck_q;
  int         act;       // chip framed by load
  int         in_bit;
  int         in_word;
  logic [4:0] out_bit;   // wraps after bit 31
  int         out_word;
  word_t      in_sh;
  word_t      first_w;
  word_t      cur_resp;  // word now going out on miso

  // only the last word of a job carries the nonce
  function automatic word_t reply_for(input int word_idx, input word_t first, input int chip);
    if (word_idx != JOB_WORDS - 1 || word_idx == 0) return ALL_ONES;
    return first ^ word_t'(chip);  // all ones here still means no nonce
  endfunction

  assign any_load = |load;
  // a zero bit pulls only the framed chip low, the rest idle high
  assign miso = cur_resp[5'd31 - out_bit] ? '1 : ~load;

  initial begin
    sck_q    = 1'b0;
    cur_resp = ALL_ONES;
    out_bit  = '0;
  end

  always @(sck or any_load) begin
    if (!any_load) begin
      in_bit   = 0;  // between jobs
      in_word  = 0;
      out_bit  = '0;
      out_word = 0;
      cur_resp = ALL_ONES;
    end else if (sck && !sck_q) begin
      if (in_bit == 0 && in_word == 0) begin
        act = $clog2(load);  // onehot to index
        job_chip.push_back(act);
      end
      in_sh = {in_sh[30:0], mosi};  // msb first
      in_bit++;
      if (in_bit == 32) begin
        job_words.push_back(in_sh);
        if (in_word == 0) first_w = in_sh;
        in_bit = 0;
        in_word++;
      end
    end else if (!sck && sck_q) begin
      out_bit++;  // mode 0, next bit after the falling edge
      if (out_bit == '0) begin
        out_word++;
        cur_resp = reply_for(out_word, first_w, act);
      end
    end
    sck_q = sck;
  end

endmodule

/* tb_api.sv */
`timescale 1ns/1ns

module tb_api import api_pkg::*; ();

  localparam int CLK_HALF  = 4;      // 8 ns period
  localparam int SEED      = 39;
  localparam int BUS_LIMIT = 20;     // cycles until ack
  localparam int JOB_LIMIT = 20000;  // cycles for any job phase
  localparam int GAP       = 20;     // timeout register
  localparam int WORDS     = 4;      // word_num
  localparam int CHANNELS  = 3;      // ch_num

  typedef enum {SIG_LOAD, SIG_IDLE, SIG_SCK} sig_t;

  logic               clk;
  logic               rst;
  logic               cyc;
  logic               stb;
  wb_req_t            wb_req;
  logic               ack;
  word_t              rd_dat;
  logic [API_NUM-1:0] load;
  logic               sck;
  logic               mosi;
  logic [API_NUM-1:0] miso;
  logic               api_idle;

  word_t pushed[$];  // job words sent over the bus
  int    visit[$];   // expected chip of each job

  api dut_i (
    .clk, .rst, .cyc, .stb, .wb_req, .ack, .rd_dat,
    .load, .sck, .mosi, .miso, .api_idle
  );

  tb_api_chip #(.JOB_WORDS(WORDS)) chip_i (.load, .sck, .mosi, .miso);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // checking
  // --------------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic expect_eq(input word_t got, input word_t exp, input string what);
    chk_eq: assert (got === exp)
      else abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, what, got, exp));
  endtask

  // no chip framed while the block reports idle
  idle_no_load: assert property (@(posedge clk) disable iff (rst) api_idle |-> load == '0)
    else abort_run($sformatf("mismatch at %0t ns: load high with api_idle", $time));

  // status fields from bit 0 up are busy, tx_drop, tx count and rx count
  function automatic word_t status_word(input int busy, input int drop, input int tx, input int rx);
    return (word_t'(rx) << (2 + CNT_W)) | (word_t'(tx) << 2) |
           (word_t'(drop) << 1) | word_t'(busy);
  endfunction

  function automatic logic probe(input sig_t sel);
    case (sel)
      SIG_LOAD: return |load;
      SIG_IDLE: return api_idle;
      default:  return sck;
    endcase
  endfunction

  // polls once per cycle 1 ns after the edge
  task automatic await_level(input sig_t sel, input logic lvl, input string what,
                             output int cycles);
    cycles = 0;
    while (probe(sel) !== lvl) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > JOB_LIMIT) abort_run($sformatf("timed out waiting for %s", what));
    end
  endtask

  // --------------------------------------------------------------------------
  // wishbone
  // --------------------------------------------------------------------------
  task automatic bus_cycle(input logic we, input logic [5:0] adr, input word_t dat,
                           output word_t rdata);
    int n;
    n      = 0;
    cyc    = 1'b1;
    stb    = 1'b1;
    wb_req = '{we: we, adr: adr, dat: dat};
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > BUS_LIMIT) abort_run("bus transfer got no ack");
    end while (!ack);
    rdata = rd_dat;  // valid with ack
    cyc   = 1'b0;
    stb   = 1'b0;
  endtask

  task automatic bus_write(input logic [5:0] adr, input word_t dat);
    word_t unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic read_check(input logic [5:0] adr, input word_t exp, input string what);
    word_t got;
    bus_cycle(1'b0, adr, '0, got);
    expect_eq(got, exp, what);
  endtask

  task automatic push_word(input word_t w);
    bus_write(ADR_DATA, w);
    pushed.push_back(w);
  endtask

  // queue one full job, watch the link and collect the nonce
  task automatic run_job(input int chip, input int div);
    word_t w;
    word_t first;
    word_t nonce;
    int    n;
    int    hi;
    int    lo;
    int    rx_n;
    for (int k = 0; k < WORDS - 1; k++) begin
      w = $urandom;
      if (k == 0) first = w;
      push_word(w);
    end
    read_check(ADR_STATUS, status_word(0, 0, WORDS - 1, 0), "status short of a job");
    expect_eq(word_t'(api_idle), 1, "api_idle short of a job");
    push_word($urandom);
    expect_eq(word_t'(api_idle), 0, "api_idle with a job queued");
    await_level(SIG_LOAD, 1'b1, "load to rise", n);
    expect_eq(word_t'(load), word_t'(1) << chip, "load line");
    await_level(SIG_SCK, 1'b1, "first sck rise", n);
    await_level(SIG_SCK, 1'b0, "sck fall", hi);
    await_level(SIG_SCK, 1'b1, "sck rise", lo);
    expect_eq(word_t'(hi), word_t'(div + 1), "sck high half period");
    expect_eq(word_t'(lo), word_t'(div + 1), "sck low half period");
    // first word on the link and the rest still queued
    read_check(ADR_STATUS, status_word(1, 0, WORDS - 1, 0), "status during job");
    await_level(SIG_LOAD, 1'b0, "load to fall", n);
    await_level(SIG_IDLE, 1'b1, "api_idle after the gap", n);
    gap_len: assert (n >= GAP && n <= GAP + 2)
      else abort_run($sformatf("mismatch at %0t ns: gap of %0d cycles", $time, n));
    nonce = first ^ word_t'(chip);
    rx_n  = (nonce != ALL_ONES) ? 1 : 0;
    read_check(ADR_STATUS, status_word(0, 0, 0, rx_n), "status after job");
    if (rx_n == 1) begin
      read_check(ADR_MINER, word_t'(chip), "miner id");
      read_check(ADR_DATA, nonce, "nonce");
    end
    read_check(ADR_DATA, ALL_ONES, "read of empty rx");
    visit.push_back(chip);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    wb_req = '0;
    void'($urandom(SEED));
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    bus_write(ADR_TIMEOUT, word_t'(GAP));
    bus_write(ADR_SCK, 2);
    bus_write(ADR_CHNUM, word_t'(CHANNELS));
    bus_write(ADR_WORDNUM, word_t'(WORDS));
    read_check(ADR_TIMEOUT, word_t'(GAP), "timeout register");
    read_check(ADR_SCK, 2, "sck register");
    read_check(ADR_CHNUM, word_t'(CHANNELS), "ch_num register");
    read_check(ADR_WORDNUM, word_t'(WORDS), "word_num register");
    read_check(ADR_STATUS, status_word(0, 0, 0, 0), "status after reset");

    for (int j = 0; j < 4; j++) run_job(j % CHANNELS, 2);  // 0 1 2 0

    bus_write(ADR_SCK, 0);  // fastest link
    run_job(1, 0);
    bus_write(ADR_SCK, 5);
    run_job(2, 5);

    // chip logs against every job queued so far
    expect_eq(word_t'(chip_i.job_chip.size()), word_t'(visit.size()), "job count");
    for (int j = 0; j < visit.size(); j++)
      expect_eq(word_t'(chip_i.job_chip[j]), word_t'(visit[j]), "chip of job");
    expect_eq(word_t'(chip_i.job_words.size()), word_t'(pushed.size()), "word count");
    for (int k = 0; k < pushed.size(); k++)
      expect_eq(chip_i.job_words[k], pushed[k], "word seen by chip");

    // overflow the tx fifo while no job can start
    bus_write(ADR_WORDNUM, 255);
    for (int k = 0; k <= TX_DEPTH; k++) bus_write(ADR_DATA, $urandom);
    read_check(ADR_STATUS, status_word(0, 1, TX_DEPTH, 0), "status after overflow");
    bus_write(ADR_FLUSH, 1);
    @(posedge clk);  // flush pulse lands
    #1;
    read_check(ADR_STATUS, status_word(0, 0, 0, 0), "status after flush");

    $display("All tests passed!");
    $finish;
  end

endmodule

/* api.f */
api_pkg.sv
api_fifo.sv
api_slave.sv
api_spi_shift.sv
api_ctrl.sv
api.sv
tb_api_chip.sv
tb_api.sv

/* Makefile */
SIM = obj_dir/Vtb_api

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module tb_api -f api.f

run: build
	out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
